/* hdl/eth_rx_pkg.sv */
`default_nettype none

package eth_rx_pkg;

    // One byte position of the receive stream
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       first;
        logic       last;
        logic       err;
    } frame_beat_t;

    // The byte received first sits in the top byte of each field
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
    } eth_header_t;

    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hd5;
    localparam int          HEADER_BYTES  = 14;
    localparam int          FCS_BYTES     = 4;
    localparam logic [31:0] CRC_INIT      = 32'hffff_ffff;

    // Residue of data plus a good FCS, written in MSB-first bit order
    localparam logic [31:0] CRC_RESIDUE   = 32'hc704_dd7b;
    localparam logic [47:0] BROADCAST_MAC = 48'hffff_ffff_ffff;

    // Reflected form of the IEEE 802.3 polynomial
    localparam logic [31:0] CRC_POLY      = 32'hedb8_8320;

    // Advances the LSB-first CRC register by one byte, low bit first as on the wire
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

/* hdl/gmii_rx_sync.sv */
`default_nettype none

module gmii_rx_sync
    import eth_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,
    output frame_beat_t beat_o
);

    logic [7:0] rx_d_q;
    logic       rx_dv_q;

    // The beat register sees the following data-valid, so a frame end is known in time
    always_ff @(posedge clk_i) begin
        rx_d_q      <= rx_d_i;
        beat_o.data <= rx_d_q;
        if (rst_i) begin
            rx_dv_q      <= 1'b0;
            beat_o.valid <= 1'b0;
            beat_o.first <= 1'b0;
            beat_o.last  <= 1'b0;
            beat_o.err   <= 1'b0;
        end else begin
            rx_dv_q      <= rx_dv_i;
            beat_o.valid <= rx_dv_q;
            beat_o.first <= rx_dv_q & ~beat_o.valid;
            beat_o.last  <= rx_dv_q & ~rx_dv_i;
            beat_o.err   <= 1'b0;
        end
    end

    // Only a byte that is present can close a frame
    a_last_is_valid: assert property (
        @(posedge clk_i) disable iff (rst_i)
        beat_o.last |-> beat_o.valid
    );

endmodule

`default_nettype wire

/* hdl/eth_preamble_strip.sv */
`default_nettype none

module eth_preamble_strip
    import eth_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  frame_beat_t beat_i,
    output frame_beat_t beat_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_DISCARD
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   sof_q;
    logic   fwd;

    assign fwd = beat_i.valid && (state_q == ST_PAYLOAD);

    always_comb begin
        state_d = state_q;
        if (beat_i.valid) begin
            case (state_q)
                ST_IDLE: begin
                    if (beat_i.first) begin
                        if (beat_i.data == PREAMBLE_BYTE) begin
                            state_d = ST_PREAMBLE;
                        end else begin
                            state_d = ST_DISCARD;
                        end
                    end
                end
                ST_PREAMBLE: begin
                    if (beat_i.data == SFD_BYTE) begin
                        state_d = ST_PAYLOAD;
                    end else if (beat_i.data != PREAMBLE_BYTE) begin
                        state_d = ST_DISCARD;
                    end
                end
                default: begin
                    state_d = state_q;
                end
            endcase
            // The end of a frame always releases the machine
            if (beat_i.last) begin
                state_d = ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        beat_o.data <= beat_i.data;
        if (rst_i) begin
            state_q      <= ST_IDLE;
            sof_q        <= 1'b0;
            beat_o.valid <= 1'b0;
            beat_o.first <= 1'b0;
            beat_o.last  <= 1'b0;
            beat_o.err   <= 1'b0;
        end else begin
            state_q      <= state_d;
            beat_o.valid <= fwd;
            beat_o.first <= fwd & sof_q;
            beat_o.last  <= fwd & beat_i.last;
            beat_o.err   <= fwd & beat_i.err;
            // Byte after the SFD opens the frame
            if (state_q == ST_PREAMBLE && state_d == ST_PAYLOAD) begin
                sof_q <= 1'b1;
            end else if (fwd) begin
                sof_q <= 1'b0;
            end
        end
    end

    a_valid_in_payload: assert property (
        @(posedge clk_i) disable iff (rst_i)
        beat_o.valid |-> $past(state_q) == ST_PAYLOAD
    );

endmodule

`default_nettype wire

/* hdl/eth_fcs_check.sv */
`default_nettype none

module eth_fcs_check
    import eth_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  frame_beat_t beat_i,
    output frame_beat_t beat_o
);

    // Entry FCS_BYTES-1 holds the oldest byte
    logic [FCS_BYTES-1:0][7:0] dline_q;
    logic [2:0]                fill_q;
    logic                      sent_q;
    logic [31:0]               crc_q;
    logic [31:0]               crc_d;
    logic [31:0]               crc_msb;
    logic                      full;
    logic                      emit;
    logic                      bad_fcs;

    assign crc_d   = crc32_byte(beat_i.first ? CRC_INIT : crc_q, beat_i.data);
    assign crc_msb = {<<{crc_d}};
    assign bad_fcs = crc_msb != CRC_RESIDUE;
    assign full    = fill_q == 3'(FCS_BYTES);

    // A held byte leaves only once the line is full of newer bytes of its own frame
    assign emit = beat_i.valid && !beat_i.first && full;

    always_ff @(posedge clk_i) begin
        if (beat_i.valid) begin
            dline_q <= {dline_q[FCS_BYTES-2:0], beat_i.data};
            crc_q   <= crc_d;
        end
        beat_o.data <= dline_q[FCS_BYTES-1];
        if (rst_i) begin
            fill_q       <= '0;
            sent_q       <= 1'b0;
            beat_o.valid <= 1'b0;
            beat_o.first <= 1'b0;
            beat_o.last  <= 1'b0;
            beat_o.err   <= 1'b0;
        end else begin
            beat_o.valid <= emit;
            beat_o.first <= emit & ~sent_q;
            beat_o.last  <= emit & beat_i.last;
            beat_o.err   <= emit & beat_i.last & bad_fcs;
            if (beat_i.valid) begin
                if (beat_i.last) begin
                    fill_q <= '0;
                end else if (beat_i.first) begin
                    fill_q <= 3'd1;
                end else if (!full) begin
                    fill_q <= fill_q + 3'd1;
                end
                if (beat_i.first) begin
                    sent_q <= 1'b0;
                end else if (emit) begin
                    sent_q <= 1'b1;
                end
            end
        end
    end

    // Nothing leaves before four bytes of the same frame have been held back
    a_emit_when_full: assert property (
        @(posedge clk_i) disable iff (rst_i)
        beat_o.valid |-> $past(fill_q) == 3'(FCS_BYTES)
    );

endmodule

`default_nettype wire

/* hdl/eth_header_parse.sv */
`default_nettype none

module eth_header_parse
    import eth_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  frame_beat_t beat_i,
    input  logic [47:0] local_mac_i,
    input  logic        promisc_i,
    output frame_beat_t beat_o,
    output eth_header_t header_o
);

    logic [3:0]                cnt_q;
    logic [3:0]                byte_idx;
    logic [HEADER_BYTES*8-1:0] hdr_q;
    logic [HEADER_BYTES*8-1:0] hdr_d;
    eth_header_t               hdr_cand;
    logic                      in_hdr;
    logic                      hdr_done;
    logic                      match;
    logic                      accept_q;
    logic                      sop_q;
    logic                      fwd;

    assign byte_idx = beat_i.first ? 4'd0 : cnt_q;
    assign in_hdr   = byte_idx < 4'(HEADER_BYTES);
    assign hdr_done = beat_i.valid && (byte_idx == 4'(HEADER_BYTES - 1));
    assign hdr_d    = {hdr_q[HEADER_BYTES*8-9:0], beat_i.data};
    assign hdr_cand = eth_header_t'(hdr_d);
    assign match    = promisc_i || (hdr_cand.dst_mac == local_mac_i)
                      || (hdr_cand.dst_mac == BROADCAST_MAC);
    assign fwd      = beat_i.valid && !in_hdr && accept_q;

    always_ff @(posedge clk_i) begin
        if (beat_i.valid && in_hdr) begin
            hdr_q <= hdr_d;
        end
        // A header is published only when payload will follow
        if (hdr_done && match && !beat_i.last) begin
            header_o <= hdr_cand;
        end
        beat_o.data <= beat_i.data;
        if (rst_i) begin
            cnt_q        <= '0;
            accept_q     <= 1'b0;
            sop_q        <= 1'b0;
            beat_o.valid <= 1'b0;
            beat_o.first <= 1'b0;
            beat_o.last  <= 1'b0;
            beat_o.err   <= 1'b0;
        end else begin
            beat_o.valid <= fwd;
            beat_o.first <= fwd & sop_q;
            beat_o.last  <= fwd & beat_i.last;
            beat_o.err   <= fwd & beat_i.err;
            if (beat_i.valid) begin
                if (in_hdr) begin
                    cnt_q <= byte_idx + 4'd1;
                end
                if (beat_i.last) begin
                    accept_q <= 1'b0;
                    sop_q    <= 1'b0;
                end else if (hdr_done) begin
                    accept_q <= match;
                    sop_q    <= match;
                end else if (fwd) begin
                    sop_q <= 1'b0;
                end
            end
        end
    end

    a_marks_in_accepted: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (beat_o.first || beat_o.last) |-> $past(accept_q)
    );

    // The header seen by the consumer holds still across the payload
    a_header_steady: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (beat_o.valid && !beat_o.first) |-> $stable(header_o)
    );

endmodule

`default_nettype wire

/* hdl/eth_rx_top.sv */
`default_nettype none

module eth_rx_top
    import eth_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [7:0]  rx_d_i,
    input  logic        rx_dv_i,
    input  logic [47:0] local_mac_i,
    input  logic        promisc_i,
    output frame_beat_t m_beat_o,
    output eth_header_t m_header_o
);

    frame_beat_t sync_beat;
    frame_beat_t frame_beat;
    frame_beat_t checked_beat;

    gmii_rx_sync i_sync (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rx_d_i  (rx_d_i),
        .rx_dv_i (rx_dv_i),
        .beat_o  (sync_beat)
    );

    eth_preamble_strip i_strip (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .beat_i (sync_beat),
        .beat_o (frame_beat)
    );

    eth_fcs_check i_fcs (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .beat_i (frame_beat),
        .beat_o (checked_beat)
    );

    eth_header_parse i_parse (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .beat_i      (checked_beat),
        .local_mac_i (local_mac_i),
        .promisc_i   (promisc_i),
        .beat_o      (m_beat_o),
        .header_o    (m_header_o)
    );

endmodule

`default_nettype wire

/* verif/eth_rx_tb.sv */
`default_nettype none

module eth_rx_tb
    import eth_rx_pkg::*;
();

    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_01;
    localparam logic [47:0] OTHER_MAC = 48'h02_00_00_00_00_99;
    localparam logic [47:0] SRC_MAC   = 48'h02_11_22_33_44_55;

    // 15 frames of at most 8 + 14 + 60 + 4 bytes plus one idle cycle each
    localparam int NUM_FRAMES = 15;
    localparam int MAX_FRAME  = 87;
    localparam int TIMEOUT    = NUM_FRAMES * (MAX_FRAME + 40) + 16;

    logic        clk_i;
    logic        rst_i;
    logic [7:0]  rx_d_i;
    logic        rx_dv_i;
    logic [47:0] local_mac_i;
    logic        promisc_i;
    frame_beat_t m_beat_o;
    eth_header_t m_header_o;

    integer      seed = 50379;
    int          err_cnt = 0;
    int          cycle_cnt = 0;
    logic [7:0]  pay_q[$];
    frame_beat_t exp_q[$];
    frame_beat_t got_q[$];
    eth_header_t exp_hdr_q[$];
    eth_header_t got_hdr_q[$];

    eth_rx_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (!rst_i && m_beat_o.valid) begin
            got_q.push_back(m_beat_o);
            if (m_beat_o.first) begin
                got_hdr_q.push_back(m_header_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Checks done with %0d errors", err_cnt + 1);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Bit-serial CRC-32, data bits taken low bit first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hedb8_8320;
            end
        end
        return c;
    endfunction

    task automatic check_val(input string name, input logic [111:0] exp,
                             input logic [111:0] act);
        assert (act === exp) else begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic put_byte(input logic [7:0] b);
        @(negedge clk_i);
        rx_d_i  = b;
        rx_dv_i = 1'b1;
    endtask

    task automatic make_payload(input int len);
        pay_q.delete();
        for (int i = 0; i < len; i++) begin
            pay_q.push_back(8'($random(seed)));
        end
    endtask

    task automatic send_frame(input eth_header_t hdr, input int hdr_len, input int pre_len,
                              input bit bad_pre, input bit bad_fcs);
        logic [7:0]  body[$];
        logic [31:0] crc;
        logic [31:0] fcs;
        crc = CRC_INIT;
        for (int i = 0; i < hdr_len; i++) begin
            body.push_back(hdr[111 - 8 * i -: 8]);
        end
        if (hdr_len == HEADER_BYTES) begin
            foreach (pay_q[i]) begin
                body.push_back(pay_q[i]);
            end
        end
        for (int i = 0; i < pre_len; i++) begin
            put_byte((bad_pre && i == pre_len - 2) ? 8'haa : PREAMBLE_BYTE);
        end
        put_byte(SFD_BYTE);
        foreach (body[i]) begin
            put_byte(body[i]);
            crc = crc_update(crc, body[i]);
        end
        // FCS goes out complemented, low byte first
        fcs = ~crc ^ {31'h0, bad_fcs};
        for (int i = 0; i < FCS_BYTES; i++) begin
            put_byte(fcs[8 * i +: 8]);
        end
        @(negedge clk_i);
        rx_dv_i = 1'b0;
        rx_d_i  = 8'h00;
    endtask

    task automatic run_frame(input logic [47:0] dst, input int len, input int pre_len,
                             input bit bad_pre, input bit bad_fcs, input bit deliver);
        eth_header_t hdr;
        frame_beat_t b;
        hdr = '{dst, SRC_MAC, 16'(16'h0800 + len)};
        make_payload(len);
        if (deliver) begin
            foreach (pay_q[i]) begin
                b.data  = pay_q[i];
                b.valid = 1'b1;
                b.first = (i == 0);
                b.last  = (i == pay_q.size() - 1);
                b.err   = b.last & bad_fcs;
                exp_q.push_back(b);
            end
            exp_hdr_q.push_back(hdr);
        end
        send_frame(hdr, HEADER_BYTES, pre_len, bad_pre, bad_fcs);
    endtask

    task automatic check_output(input string test);
        int n;
        n = 0;
        while (got_q.size() < exp_q.size() && n < 40) begin
            @(negedge clk_i);
            n++;
        end
        // An extra beat would show up within the pipeline latency
        repeat (16) @(negedge clk_i);
        assert (got_q.size() == exp_q.size()) else begin
            $display("%s: expected %0d payload beats but received %0d",
                     test, exp_q.size(), got_q.size());
            err_cnt++;
        end
        assert (got_hdr_q.size() == exp_hdr_q.size()) else begin
            $display("%s: expected %0d frames but received %0d",
                     test, exp_hdr_q.size(), got_hdr_q.size());
            err_cnt++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_val("m_beat_o.data", 112'(exp_q[i].data), 112'(got_q[i].data));
            check_val("m_beat_o.first", 112'(exp_q[i].first), 112'(got_q[i].first));
            check_val("m_beat_o.last", 112'(exp_q[i].last), 112'(got_q[i].last));
            check_val("m_beat_o.err", 112'(exp_q[i].err), 112'(got_q[i].err));
        end
        for (int i = 0; i < exp_hdr_q.size() && i < got_hdr_q.size(); i++) begin
            check_val("m_header_o", exp_hdr_q[i], got_hdr_q[i]);
        end
        exp_q.delete();
        got_q.delete();
        exp_hdr_q.delete();
        got_hdr_q.delete();
    endtask

    task automatic test_good_frame();
        run_frame(LOCAL_MAC, 20, 7, 1'b0, 1'b0, 1'b1);
        check_output("good frame");
    endtask

    task automatic test_bad_fcs();
        run_frame(LOCAL_MAC, 20, 7, 1'b0, 1'b1, 1'b1);
        check_output("corrupted FCS");
    endtask

    task automatic test_address_filter();
        run_frame(OTHER_MAC, 12, 7, 1'b0, 1'b0, 1'b0);
        check_output("other MAC");
        run_frame(BROADCAST_MAC, 12, 7, 1'b0, 1'b0, 1'b1);
        check_output("broadcast");
        @(negedge clk_i);
        promisc_i = 1'b1;
        run_frame(OTHER_MAC, 12, 7, 1'b0, 1'b0, 1'b1);
        check_output("promiscuous");
        @(negedge clk_i);
        promisc_i = 1'b0;
    endtask

    task automatic test_framing_faults();
        eth_header_t hdr;
        hdr = '{LOCAL_MAC, SRC_MAC, 16'h0800};
        run_frame(LOCAL_MAC, 16, 2, 1'b0, 1'b0, 1'b1);
        check_output("short preamble");
        run_frame(LOCAL_MAC, 16, 7, 1'b1, 1'b0, 1'b0);
        run_frame(LOCAL_MAC, 16, 7, 1'b0, 1'b0, 1'b1);
        check_output("bad preamble byte");
        // Frame that stops after ten header bytes
        send_frame(hdr, 10, 7, 1'b0, 1'b0);
        run_frame(LOCAL_MAC, 16, 7, 1'b0, 1'b0, 1'b1);
        check_output("truncated header");
    endtask

    task automatic test_back_to_back();
        int len;
        for (int f = 0; f < 5; f++) begin
            len = 1 + ({$random(seed)} % 60);
            run_frame(LOCAL_MAC, len, 7, 1'b0, 1'b0, 1'b1);
        end
        check_output("back-to-back");
    endtask

    initial begin
        rst_i       = 1'b1;
        rx_d_i      = 8'h00;
        rx_dv_i     = 1'b0;
        local_mac_i = LOCAL_MAC;
        promisc_i   = 1'b0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        test_good_frame();
        test_bad_fcs();
        test_address_filter();
        test_framing_faults();
        test_back_to_back();
        $display("Checks done with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* eth_rx.f */
hdl/eth_rx_pkg.sv
hdl/gmii_rx_sync.sv
hdl/eth_preamble_strip.sv
hdl/eth_fcs_check.sv
hdl/eth_header_parse.sv
hdl/eth_rx_top.sv
verif/eth_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= eth_rx_tb
FILELIST  ?= eth_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
